// ==== design/mipsIsaPkg.sv ====
package mipsIsaPkg;

	// register specifiers are 5 bits wide in every MIPS encoding
	localparam int RegAddrW = 5;
	localparam logic [RegAddrW-1:0] RaReg = 5'd31; // link register

	typedef enum logic [3:0] {
		opAdd,
		opSub,
		opAnd,
		opOr,
		opXor,
		opNor,
		opSlt, // signed compare
		opSll,
		opSrl,
		opLui,
		opLink // pc+8 for jal/jalr/bgezal style ops
	} aluOp_e;

	// operand A is rs or shamt
	typedef enum logic {
		srcARs,
		srcAShamt
	} srcA_e;

	// operand B is rt or the immediate
	typedef enum logic {
		srcBRt,
		srcBImm
	} srcB_e;

	// which field names the destination register
	typedef enum logic [1:0] {
		dstRt,
		dstRd,
		dstRa
	} dstSel_e;

endpackage

// ==== design/pipeCtrlPkg.sv ====
package pipeCtrlPkg;

	// where an operand is taken from in the issue cycle
	// ordered from the register file through the youngest to oldest stage
	typedef enum logic [2:0] {
		fwdReg,
		fwdEx,
		fwdMem1,
		fwdMem2,
		fwdWb
	} fwdSrc_e;

endpackage

// ==== design/regFile.sv ====
module regFile import mipsIsaPkg::*; #(
	parameter int DataW = 32,
	parameter int NumReadPorts = 2
) (
	input  logic clk,
	input  logic rst,
	input  logic [NumReadPorts-1:0][RegAddrW-1:0] rdAddr,
	output logic [NumReadPorts-1:0][DataW-1:0] rdData,
	input  logic wrEn,
	input  logic [RegAddrW-1:0] wrAddr,
	input  logic [DataW-1:0] wrData
);

	logic [DataW-1:0] regs [1:31]; // r0 is not stored

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int r = 1; r < 32; r++) begin
				regs[r] <= '0;
			end
		end else if (wrEn && wrAddr != '0) begin
			regs[wrAddr] <= wrData;
		end
	end

	// write-through so a same-cycle read sees the writeback value
	always_comb begin
		for (int p = 0; p < NumReadPorts; p++) begin
			if (rdAddr[p] == '0)
				rdData[p] = '0;
			else if (wrEn && wrAddr == rdAddr[p])
				rdData[p] = wrData;
			else
				rdData[p] = regs[rdAddr[p]];
		end
	end

endmodule

// ==== design/fwdControl.sv ====
module fwdControl import mipsIsaPkg::*, pipeCtrlPkg::*; #(
	parameter int NumReadPorts = 2
) (
	input  logic [NumReadPorts-1:0][RegAddrW-1:0] rdAddr,
	input  logic exValid,
	input  logic [RegAddrW-1:0] exDst,
	input  logic mem1Valid,
	input  logic [RegAddrW-1:0] mem1Dst,
	input  logic mem2Valid,
	input  logic [RegAddrW-1:0] mem2Dst,
	input  logic wbValid,
	input  logic [RegAddrW-1:0] wbDst,
	output fwdSrc_e [NumReadPorts-1:0] fwdSel
);

	// a stage only counts if it holds a real instruction writing a nonzero reg
	function automatic logic hit(
		input logic v,
		input logic [RegAddrW-1:0] dst,
		input logic [RegAddrW-1:0] addr
	);
		return v && (dst == addr) && (addr != '0);
	endfunction

	always_comb begin
		for (int p = 0; p < NumReadPorts; p++) begin
			// youngest producer wins
			if (hit(exValid, exDst, rdAddr[p]))
				fwdSel[p] = fwdEx;
			else if (hit(mem1Valid, mem1Dst, rdAddr[p]))
				fwdSel[p] = fwdMem1;
			else if (hit(mem2Valid, mem2Dst, rdAddr[p]))
				fwdSel[p] = fwdMem2;
			else if (hit(wbValid, wbDst, rdAddr[p]))
				fwdSel[p] = fwdWb; // same value the write-through gives
			else
				fwdSel[p] = fwdReg;
		end
	end

endmodule

// ==== design/operandForward.sv ====
module operandForward import pipeCtrlPkg::*; #(
	parameter int DataW = 32
) (
	input  fwdSrc_e fwdSel,
	input  logic [DataW-1:0] regData,
	input  logic [DataW-1:0] exResult,
	input  logic [DataW-1:0] mem1Result,
	input  logic [DataW-1:0] mem2Result,
	input  logic [DataW-1:0] wbResult,
	output logic [DataW-1:0] fwdData
);

	always_comb begin
		case (fwdSel)
			fwdEx:   fwdData = exResult;
			fwdMem1: fwdData = mem1Result;
			fwdMem2: fwdData = mem2Result;
			fwdWb:   fwdData = wbResult;
			default: fwdData = regData; // fwdReg
		endcase
	end

endmodule

// ==== design/exeStage.sv ====
module exeStage import mipsIsaPkg::*; #(
	parameter int DataW = 32
) (
	input  logic clk,
	input  logic rst,
	input  logic issueValid,
	input  aluOp_e issueOp,
	input  srcA_e issueSrcA,
	input  srcB_e issueSrcB,
	input  dstSel_e issueDstSel,
	input  logic [RegAddrW-1:0] issueRt,
	input  logic [RegAddrW-1:0] issueRd,
	input  logic [4:0] issueShamt,
	input  logic [DataW-1:0] issueImm,
	input  logic [DataW-1:0] issuePc,
	input  logic [DataW-1:0] rsData,
	input  logic [DataW-1:0] rtData,
	output logic exValid,
	output logic [RegAddrW-1:0] exDst,
	output logic [DataW-1:0] exResult,
	output logic mem1Valid,
	output logic [RegAddrW-1:0] mem1Dst,
	output logic [DataW-1:0] mem1Result,
	output logic mem2Valid,
	output logic [RegAddrW-1:0] mem2Dst,
	output logic [DataW-1:0] mem2Result,
	output logic wbValid,
	output logic [RegAddrW-1:0] wbDst,
	output logic [DataW-1:0] wbResult
);

	logic [RegAddrW-1:0] issueDst;
	aluOp_e exOp;
	srcA_e exSrcA;
	srcB_e exSrcB;
	logic [4:0] exShamt;
	logic [DataW-1:0] exImm, exPc, exRs, exRt;
	logic [DataW-1:0] opA, opB;

	always_comb begin
		case (issueDstSel)
			dstRt:   issueDst = issueRt;
			dstRd:   issueDst = issueRd;
			default: issueDst = RaReg;
		endcase
	end

	// valid bits travel with each instruction
	always_ff @(posedge clk) begin
		if (rst) begin
			exValid <= 1'b0;
			mem1Valid <= 1'b0;
			mem2Valid <= 1'b0;
			wbValid <= 1'b0;
		end else begin
			exValid <= issueValid;
			mem1Valid <= exValid;
			mem2Valid <= mem1Valid;
			wbValid <= mem2Valid;
		end
	end

	always_ff @(posedge clk) begin
		exOp <= issueOp;
		exSrcA <= issueSrcA;
		exSrcB <= issueSrcB;
		exDst <= issueDst;
		exShamt <= issueShamt;
		exImm <= issueImm;
		exPc <= issuePc;
		exRs <= rsData; // already forwarded
		exRt <= rtData;
		mem1Dst <= exDst;
		mem1Result <= exResult;
		mem2Dst <= mem1Dst;
		mem2Result <= mem1Result;
		wbDst <= mem2Dst;
		wbResult <= mem2Result;
	end

	assign opA = (exSrcA == srcAShamt) ? DataW'(exShamt) : exRs;
	assign opB = (exSrcB == srcBImm) ? exImm : exRt;

	always_comb begin
		case (exOp)
			opAdd:   exResult = opA + opB;
			opSub:   exResult = opA - opB;
			opAnd:   exResult = opA & opB;
			opOr:    exResult = opA | opB;
			opXor:   exResult = opA ^ opB;
			opNor:   exResult = ~(opA | opB);
			opSlt:   exResult = DataW'($signed(opA) < $signed(opB));
			opSll:   exResult = opB << opA[4:0];
			opSrl:   exResult = opB >> opA[4:0];
			// sign-extended above bit 31 when the datapath is 64 wide
			opLui:   exResult = DataW'($signed({exImm[15:0], 16'h0000}));
			default: exResult = exPc + DataW'(8); // opLink
		endcase
	end

endmodule

// ==== design/exePipe.sv ====
module exePipe import mipsIsaPkg::*, pipeCtrlPkg::*; #(
	parameter int DataW = 32,
	parameter int NumReadPorts = 2
) (
	input  logic clk,
	input  logic rst,
	input  logic issueValid,
	input  aluOp_e issueOp,
	input  srcA_e issueSrcA,
	input  srcB_e issueSrcB,
	input  dstSel_e issueDstSel,
	input  logic [RegAddrW-1:0] issueRs,
	input  logic [RegAddrW-1:0] issueRt,
	input  logic [RegAddrW-1:0] issueRd,
	input  logic [4:0] issueShamt,
	input  logic [DataW-1:0] issueImm,
	input  logic [DataW-1:0] issuePc,
	output logic wbValid,
	output logic [RegAddrW-1:0] wbAddr,
	output logic [DataW-1:0] wbData
);

	logic [NumReadPorts-1:0][RegAddrW-1:0] rdAddr;
	logic [NumReadPorts-1:0][DataW-1:0] regData, fwdData;
	fwdSrc_e [NumReadPorts-1:0] fwdSel;
	logic exValid, mem1Valid, mem2Valid;
	logic [RegAddrW-1:0] exDst, mem1Dst, mem2Dst;
	logic [DataW-1:0] exResult, mem1Result, mem2Result;

	regFile #(.DataW(DataW), .NumReadPorts(NumReadPorts)) uRegFile (
		.clk(clk), .rst(rst),
		.rdAddr(rdAddr), .rdData(regData),
		.wrEn(wbValid), .wrAddr(wbAddr), .wrData(wbData)
	);

	fwdControl #(.NumReadPorts(NumReadPorts)) uFwdControl (
		.rdAddr(rdAddr),
		.exValid(exValid), .exDst(exDst),
		.mem1Valid(mem1Valid), .mem1Dst(mem1Dst),
		.mem2Valid(mem2Valid), .mem2Dst(mem2Dst),
		.wbValid(wbValid), .wbDst(wbAddr),
		.fwdSel(fwdSel)
	);

	// port 0 reads rs, port 1 reads rt
	for (genvar i = 0; i < NumReadPorts; i++) begin : gFwd
		assign rdAddr[i] = (i == 0) ? issueRs : issueRt;

		operandForward #(.DataW(DataW)) uOperandForward (
			.fwdSel(fwdSel[i]), .regData(regData[i]),
			.exResult(exResult), .mem1Result(mem1Result),
			.mem2Result(mem2Result), .wbResult(wbData),
			.fwdData(fwdData[i])
		);
	end

	exeStage #(.DataW(DataW)) uExeStage (
		.clk(clk), .rst(rst),
		.issueValid(issueValid), .issueOp(issueOp),
		.issueSrcA(issueSrcA), .issueSrcB(issueSrcB), .issueDstSel(issueDstSel),
		.issueRt(issueRt), .issueRd(issueRd), .issueShamt(issueShamt),
		.issueImm(issueImm), .issuePc(issuePc),
		.rsData(fwdData[0]), .rtData(fwdData[1]),
		.exValid(exValid), .exDst(exDst), .exResult(exResult),
		.mem1Valid(mem1Valid), .mem1Dst(mem1Dst), .mem1Result(mem1Result),
		.mem2Valid(mem2Valid), .mem2Dst(mem2Dst), .mem2Result(mem2Result),
		.wbValid(wbValid), .wbDst(wbAddr), .wbResult(wbData)
	);

endmodule

// ==== sim/exePipe_chk.sv ====
module exePipe_chk import mipsIsaPkg::*; #(
	parameter int DataW = 32
) (
	input logic clk,
	input logic rst,
	input logic issueValid,
	input aluOp_e issueOp,
	input srcA_e issueSrcA,
	input srcB_e issueSrcB,
	input dstSel_e issueDstSel,
	input logic [RegAddrW-1:0] issueRs,
	input logic [RegAddrW-1:0] issueRt,
	input logic [RegAddrW-1:0] issueRd,
	input logic [4:0] issueShamt,
	input logic [DataW-1:0] issueImm,
	input logic [DataW-1:0] issuePc,
	input logic wbValid,
	input logic [RegAddrW-1:0] wbAddr,
	input logic [DataW-1:0] wbData
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [DataW-1:0] shadow [32]; // architectural state in program order
	logic [DataW-1:0] opA, opB, nextRes;
	logic [RegAddrW-1:0] nextDst;
	logic [3:0] expValid;
	logic [3:0][RegAddrW-1:0] expDst;
	logic [3:0][DataW-1:0] expRes;
	int errCount = 0;

	always_comb begin
		opA = (issueSrcA == srcAShamt) ? DataW'(issueShamt) : shadow[issueRs];
		opB = (issueSrcB == srcBImm) ? issueImm : shadow[issueRt];
		case (issueDstSel)
			dstRt:   nextDst = issueRt;
			dstRd:   nextDst = issueRd;
			default: nextDst = 5'd31;
		endcase
		case (issueOp)
			opAdd:   nextRes = opA + opB;
			opSub:   nextRes = opA - opB;
			opAnd:   nextRes = opA & opB;
			opOr:    nextRes = opA | opB;
			opXor:   nextRes = opA ^ opB;
			opNor:   nextRes = ~(opA | opB);
			opSlt:   nextRes = ($signed(opA) < $signed(opB)) ? DataW'(1) : '0;
			opSll:   nextRes = opB << opA[4:0];
			opSrl:   nextRes = opB >> opA[4:0];
			opLui:   nextRes = DataW'($signed(issueImm[15:0])) << 16;
			opLink:  nextRes = issuePc + DataW'(8);
			default: nextRes = '0;
		endcase
	end

	// four-deep delay line lines up with the writeback port
	always @(posedge clk) begin
		expDst <= {expDst[2:0], nextDst};
		expRes <= {expRes[2:0], nextRes};
		if (rst) begin
			expValid <= '0;
			for (int r = 0; r < 32; r++) begin
				shadow[r] <= '0;
			end
		end else begin
			expValid <= {expValid[2:0], issueValid};
			if (issueValid && nextDst != '0)
				shadow[nextDst] <= nextRes; // r0 stays zero
		end
	end

	assert property (@(posedge clk) rst |=> !wbValid)
		else begin
			errCount++;
			$error("wbValid high in the cycle after a reset cycle");
		end

	assert property (@(posedge clk) disable iff (rst) wbValid == expValid[3])
		else begin
			errCount++;
			$error("Mismatch wbValid: got %h, expected %h", $sampled(wbValid),
				$sampled(expValid[3]));
		end

	assert property (@(posedge clk) disable iff (rst) wbValid |-> wbAddr == expDst[3])
		else begin
			errCount++;
			$error("Mismatch wbAddr: got %h, expected %h", $sampled(wbAddr),
				$sampled(expDst[3]));
		end

	assert property (@(posedge clk) disable iff (rst) wbValid |-> wbData == expRes[3])
		else begin
			errCount++;
			$error("Mismatch wbData: got %h, expected %h", $sampled(wbData),
				$sampled(expRes[3]));
		end

endmodule

bind exePipe exePipe_chk #(.DataW(DataW)) uChk (
	.clk(clk), .rst(rst), .issueValid(issueValid), .issueOp(issueOp),
	.issueSrcA(issueSrcA), .issueSrcB(issueSrcB), .issueDstSel(issueDstSel),
	.issueRs(issueRs), .issueRt(issueRt), .issueRd(issueRd),
	.issueShamt(issueShamt), .issueImm(issueImm), .issuePc(issuePc),
	.wbValid(wbValid), .wbAddr(wbAddr), .wbData(wbData)
);

// ==== sim/exePipe_tb.sv ====
module exePipe_tb import mipsIsaPkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int DataW = 32;

	logic clk = 1'b0;
	logic rst;
	logic issueValid;
	aluOp_e issueOp;
	srcA_e issueSrcA;
	srcB_e issueSrcB;
	dstSel_e issueDstSel;
	logic [RegAddrW-1:0] issueRs, issueRt, issueRd;
	logic [4:0] issueShamt;
	logic [DataW-1:0] issueImm, issuePc;
	logic wbValid;
	logic [RegAddrW-1:0] wbAddr;
	logic [DataW-1:0] wbData;

	logic [31:0] lfsr = 32'h2b45_9c8b;
	logic [DataW-1:0] pc = 32'h0040_0000;
	int issueCount = 0;
	int wbCount = 0;
	int timeoutCount = 0;

	exePipe #(.DataW(DataW), .NumReadPorts(2)) dut (.*);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		if (!rst && wbValid)
			wbCount <= wbCount + 1;
	end

	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrStep(lfsr);
			v = {v[30:0], lfsr[0]}; // one step per bit
		end
		return v;
	endfunction

	task automatic issue(input logic v, input aluOp_e op, input srcA_e a, input srcB_e b,
			input dstSel_e d, input logic [4:0] rs, input logic [4:0] rt,
			input logic [4:0] rd, input logic [4:0] sh, input logic [DataW-1:0] imm);
		issueValid = v;
		issueOp = op;
		issueSrcA = a;
		issueSrcB = b;
		issueDstSel = d;
		issueRs = rs;
		issueRt = rt;
		issueRd = rd;
		issueShamt = sh;
		issueImm = imm;
		issuePc = pc;
		pc = pc + 32'd4;
		if (v)
			issueCount++;
		@(posedge clk);
		#1;
	endtask

	task automatic alu(input aluOp_e op, input logic [4:0] rs, input logic [4:0] rt,
			input logic [4:0] rd);
		issue(1'b1, op, srcARs, srcBRt, dstRd, rs, rt, rd, 5'd0, '0);
	endtask

	task automatic aluImm(input aluOp_e op, input logic [4:0] rs, input logic [4:0] rt,
			input logic [DataW-1:0] imm);
		issue(1'b1, op, srcARs, srcBImm, dstRt, rs, rt, 5'd0, 5'd0, imm);
	endtask

	task automatic issueRandom();
		logic v;
		aluOp_e op;
		srcA_e a;
		srcB_e b;
		dstSel_e d;
		logic [4:0] r [3];
		logic [4:0] sh;
		logic [15:0] imm;
		v = (randBits(3) != 0); // roughly one bubble in eight
		op = aluOp_e'(4'(randBits(4) % 11));
		a = srcA_e'(1'(randBits(1)));
		b = srcB_e'(1'(randBits(1)));
		d = dstSel_e'(2'(randBits(2) % 3));
		for (int k = 0; k < 3; k++) begin
			r[k] = (randBits(2) != 0) ? 5'(randBits(3)) : 5'(randBits(5)); // mostly r0..r7
		end
		sh = 5'(randBits(5));
		imm = 16'(randBits(16));
		issue(v, op, a, b, d, r[0], r[1], r[2], sh, {{16{imm[15]}}, imm});
	endtask

	task automatic waitDrain(input int limit);
		int n;
		n = 0;
		issueValid = 1'b0;
		while (wbCount != issueCount && n < limit) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (wbCount != issueCount) begin
			timeoutCount++;
			$display("timeout: only %0d of %0d instructions reached writeback in %0d cycles",
				wbCount, issueCount, limit);
		end
	endtask

	initial begin
		rst = 1'b1;
		issueValid = 1'b0;
		issueOp = opAdd;
		issueSrcA = srcARs;
		issueSrcB = srcBRt;
		issueDstSel = dstRt;
		issueRs = '0;
		issueRt = '0;
		issueRd = '0;
		issueShamt = '0;
		issueImm = '0;
		issuePc = '0;
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;

		aluImm(opLui, 5'd0, 5'd5, 32'h0000_1234);
		aluImm(opOr, 5'd5, 5'd5, 32'h0000_5678); // consumer at distance 1
		issue(1'b1, opLink, srcARs, srcBRt, dstRa, 5'd0, 5'd0, 5'd0, 5'd0, '0);
		alu(opAdd, 5'd31, 5'd0, 5'd6);
		aluImm(opAdd, 5'd0, 5'd0, 32'h0000_00ff); // r0 write still reaches WB
		alu(opOr, 5'd0, 5'd0, 5'd7);
		issue(1'b0, opAdd, srcARs, srcBImm, dstRt, 5'd0, 5'd4, 5'd0, 5'd0, 32'h0bad);
		alu(opAdd, 5'd4, 5'd0, 5'd3); // bubble must not forward into r4

		for (int d = 1; d <= 4; d++) begin
			aluImm(opAdd, 5'd0, 5'd2, 32'(d * 17));
			repeat (d - 1) aluImm(opXor, 5'd7, 5'd7, 32'h0000_0001);
			alu(opSub, 5'd2, 5'd5, 5'd1);
		end

		issue(1'b1, opSll, srcAShamt, srcBRt, dstRd, 5'd0, 5'd5, 5'd8, 5'd7, '0);
		issue(1'b1, opSrl, srcARs, srcBRt, dstRd, 5'd1, 5'd8, 5'd9, 5'd0, '0);
		aluImm(opSlt, 5'd8, 5'd10, 32'hffff_fff0); // signed compare against a negative

		for (int i = 0; i < 400; i++) begin
			issueRandom();
		end
		waitDrain(20);

		$display("errors: %0d assertion failures, %0d timeouts",
			dut.uChk.errCount, timeoutCount);
		if (dut.uChk.errCount == 0 && timeoutCount == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// ==== all.f ====
design/mipsIsaPkg.sv
design/pipeCtrlPkg.sv
design/regFile.sv
design/fwdControl.sv
design/operandForward.sv
design/exeStage.sv
design/exePipe.sv
sim/exePipe_chk.sv
sim/exePipe_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the exePipe testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f all.f --top-module exePipe_tb -o exePipe_sim \
	&& ./obj_dir/exePipe_sim +verilator+error+limit+100000 > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "simulation reported failure"; exit 1; }
exit 0
